//--- tb/rv_checker.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_checker (
  input logic                  clk,
  input logic                  reset,
  input logic                  mem_valid,
  input logic                  mem_instr,
  input logic                  mem_ready,
  input logic [`RV_XLEN-1:0]   mem_addr,
  input logic [`RV_XLEN-1:0]   mem_wdata,
  input logic [`RV_STRB_W-1:0] mem_wstrb,
  input logic                  trap
);
  import rv_pkg::*;

  logic [31:0] mmem [2048];
  logic [31:0] regs [32];
  logic [31:0] pc, trap_pc, last_fetch;
  logic model_trapped, trap_seen, prev_valid, alu_fetch;
  logic prev_reset = 1'b0;
  int errors = 0;
  int cyc = 0;
  int done_cyc = 0;
  logic [31:0] exp_addr [$];
  logic [3:0] exp_strb [$];
  logic [31:0] exp_wdata [$];

  function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic step(input logic [31:0] ins);
    opcode_e opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_j, nxt, tgt, ea, lane, val, sdata;
    logic [3:0] strb;
    logic bad, wr, take, mis;
    opc = opcode_e'(ins[6:2]);
    f3 = ins[14:12];
    f7 = ins[31:25];
    a = regs[ins[19:15]];
    b = regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt = pc + 4;
    bad = ins[1:0] != 2'b11;
    wr = 1'b0;
    val = '0;
    ea = '0;
    case (opc)
      OPC_LUI: begin
        wr = 1'b1;
        val = {ins[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        wr = 1'b1;
        val = pc + {ins[31:12], 12'b0};
      end
      OPC_JAL, OPC_JALR: begin
        tgt = (opc == OPC_JAL) ? pc + imm_j : (a + imm_i) & ~32'h1;
        if (opc == OPC_JALR && f3 != 3'd0) bad = 1'b1;
        if (tgt[1:0] != 2'b00) bad = 1'b1;
        wr = 1'b1;
        val = pc + 4;
        nxt = tgt;
      end
      OPC_BRANCH: begin
        case (f3)
          3'd0: take = a == b;
          3'd1: take = a != b;
          3'd4: take = $signed(a) < $signed(b);
          3'd5: take = $signed(a) >= $signed(b);
          3'd6: take = a < b;
          3'd7: take = a >= b;
          default: begin
            take = 1'b0;
            bad = 1'b1;
          end
        endcase
        tgt = pc + imm_b;
        if (take && tgt[1:0] != 2'b00) bad = 1'b1;
        if (take) nxt = tgt;
      end
      OPC_LOAD, OPC_STORE: begin
        ea = a + ((opc == OPC_LOAD) ? imm_i : imm_s);
        mis = (f3[1:0] == 2'b01 && ea[0]) || (f3[1:0] == 2'b10 && ea[1:0] != 2'b00);
        if (opc == OPC_LOAD && (f3 == 3'd3 || f3[2:1] == 2'b11)) bad = 1'b1;
        if (opc == OPC_STORE && f3 > 3'd2) bad = 1'b1;
        if (mis) bad = 1'b1;
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1 && f7 != 7'h00) bad = 1'b1;
        if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) bad = 1'b1;
        wr = 1'b1;
        val = alu_calc(f3, f3 == 3'd5 && f7[5], a, imm_i);
      end
      OPC_OP: begin
        if (!(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) bad = 1'b1;
        wr = 1'b1;
        val = alu_calc(f3, f7[5], a, b);
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      model_trapped = 1'b1;
      trap_pc = pc;
    end else begin
      if (opc == OPC_LOAD) begin
        lane = mmem[ea[12:2]] >> {ea[1:0], 3'b000};
        case (f3)
          3'd0: val = {{24{lane[7]}}, lane[7:0]};
          3'd4: val = {24'b0, lane[7:0]};
          3'd1: val = {{16{lane[15]}}, lane[15:0]};
          3'd5: val = {16'b0, lane[15:0]};
          default: val = lane;
        endcase
        wr = 1'b1;
        exp_addr.push_back({ea[31:2], 2'b00});
        exp_strb.push_back(4'b0000);
        exp_wdata.push_back('0);
      end
      if (opc == OPC_STORE) begin
        case (f3)
          3'd0: begin
            strb = 4'b0001 << ea[1:0];
            sdata = {4{b[7:0]}};
          end
          3'd1: begin
            strb = ea[1] ? 4'b1100 : 4'b0011;
            sdata = {2{b[15:0]}};
          end
          default: begin
            strb = 4'b1111;
            sdata = b;
          end
        endcase
        for (int k = 0; k < 4; k++) begin
          if (strb[k]) mmem[ea[12:2]][8*k +: 8] = sdata[8*k +: 8];
        end
        exp_addr.push_back({ea[31:2], 2'b00});
        exp_strb.push_back(strb);
        exp_wdata.push_back(sdata);
      end
      if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = val;
      alu_fetch = opc == OPC_LUI || opc == OPC_AUIPC || opc == OPC_OP || opc == OPC_OP_IMM;
      pc = nxt;
    end
  endtask

  always @(posedge clk) begin
    cyc++;
    if (reset) begin
      if (prev_reset && (mem_valid !== 1'b0 || mem_wstrb !== '0 || trap !== 1'b0)) begin
        $display("mem_valid, mem_wstrb or trap not low during reset");
        errors++;
      end
      pc = `RV_RESET_PC;
      // x0 is never written by the model
      regs[0] = '0;
      model_trapped = 1'b0;
      trap_seen = 1'b0;
      alu_fetch = 1'b0;
      prev_valid = 1'b0;
      exp_addr.delete();
      exp_strb.delete();
      exp_wdata.delete();
    end else begin
      // request raised at the 4th edge after the completing one
      if (mem_valid && mem_instr && !prev_valid && alu_fetch) begin
        if (cyc - done_cyc != 5) begin
          $display("ALU instruction took %0d cycles to the next fetch", cyc - done_cyc - 1);
          errors++;
        end
        alu_fetch = 1'b0;
      end
      if (mem_valid && mem_ready && mem_instr) begin
        if (model_trapped) begin
          $display("fetch at %h after the model trapped", mem_addr);
          errors++;
        end else begin
          if (mem_addr !== pc) begin
            $display("Mismatch mem_addr (fetch): expected %h got %h", pc, mem_addr);
            errors++;
          end
          if (mem_wstrb !== 4'h0) begin
            $display("Mismatch mem_wstrb (fetch): expected 0 got %h", mem_wstrb);
            errors++;
          end
          last_fetch = mem_addr;
          done_cyc = cyc;
          alu_fetch = 1'b0;
          step(mmem[pc[12:2]]);
        end
      end
      if (mem_valid && mem_ready && !mem_instr) begin
        if (exp_addr.size() == 0) begin
          $display("data transfer at %h that the model did not expect", mem_addr);
          errors++;
        end else begin
          if (mem_addr !== exp_addr[0]) begin
            $display("Mismatch mem_addr: expected %h got %h", exp_addr[0], mem_addr);
            errors++;
          end
          if (mem_wstrb !== exp_strb[0]) begin
            $display("Mismatch mem_wstrb: expected %h got %h", exp_strb[0], mem_wstrb);
            errors++;
          end
          if (exp_strb[0] != 4'h0 && mem_wdata !== exp_wdata[0]) begin
            $display("Mismatch mem_wdata: expected %h got %h", exp_wdata[0], mem_wdata);
            errors++;
          end
          void'(exp_addr.pop_front());
          void'(exp_strb.pop_front());
          void'(exp_wdata.pop_front());
        end
      end
      if (trap === 1'b1 && !trap_seen) begin
        trap_seen = 1'b1;
        if (!model_trapped) begin
          $display("trap raised at %h but the model did not trap", last_fetch);
          errors++;
        end else if (last_fetch !== trap_pc) begin
          $display("Mismatch trap pc: expected %h got %h", trap_pc, last_fetch);
          errors++;
        end
      end
      if (trap_seen && mem_valid) begin
        $display("bus request after trap at %h", mem_addr);
        errors++;
      end
      prev_valid = mem_valid;
    end
    prev_reset = reset;
  end

endmodule

//--- tb/rv_core_assertions.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core_assertions (
  input logic                  clk,
  input logic                  reset,
  input logic                  mem_valid,
  input logic                  mem_ready,
  input logic [`RV_XLEN-1:0]   mem_addr,
  input logic [`RV_XLEN-1:0]   mem_wdata,
  input logic [`RV_STRB_W-1:0] mem_wstrb,
  input logic                  trap,
  input rv_pkg::cpu_state_e    state
);
  import rv_pkg::*;

  int fail_count = 0;

  // a waiting request keeps its address, data and strobes
  hold_request: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> mem_valid && mem_addr === $past(mem_addr) &&
      mem_wdata === $past(mem_wdata) && mem_wstrb === $past(mem_wstrb))
    else begin
      fail_count++;
      $error("bus request changed while waiting for mem_ready");
    end

  no_request_in_trap: assert property (@(posedge clk) disable iff (reset)
      state == ST_TRAP |-> !mem_valid)
    else begin
      fail_count++;
      $error("mem_valid high in the trap state");
    end

  trap_sticky: assert property (@(posedge clk) disable iff (reset)
      trap |=> trap)
    else begin
      fail_count++;
      $error("trap fell without reset");
    end

endmodule

bind rv_control rv_core_assertions u_assertions (.*);

//--- tb/tb_rv_core.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int NUM_TESTS = 8;
  localparam int PROG_LEN = 48;
  localparam int MEM_WORDS = 2048;
  localparam longint WATCHDOG_NS = NUM_TESTS * (PROG_LEN * 12 + 20) * 20;

  logic clk = 1'b0;
  logic reset, mem_valid, mem_instr, mem_ready, trap;
  logic [`RV_XLEN-1:0] mem_addr, mem_wdata, mem_rdata;
  logic [`RV_STRB_W-1:0] mem_wstrb;
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rng_state;
  int wait_cnt, prev_errs, test_errs, failed_tests;

  rv_core i_dut (.*);
  rv_checker u_checker (.*);

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(1 + next_rand() % 7);
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd31, f3, imm[4:0], OPC_STORE, 2'b11};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], rand_reg(), rand_reg(), f3, imm[4:1], imm[11], OPC_BRANCH,
            2'b11};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
  endfunction

  function automatic logic [31:0] random_alu();
    logic [31:0] r;
    logic [11:0] imm;
    logic [2:0] f3;
    logic [6:0] f7;
    r = next_rand();
    imm = 12'(next_rand());
    f3 = r[2:0];
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[5]) ? 7'h20 : 7'h00;
    if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = (f3 == 3'd5) ? f7 : 7'h00;
    case (r[4:3])
      2'd2: return enc_i(imm, rand_reg(), f3, rand_reg(), OPC_OP_IMM);
      2'd3: return {r[31:12], rand_reg(), r[5] ? OPC_LUI : OPC_AUIPC, 2'b11};
      default: return {f7, rand_reg(), rand_reg(), f3, rand_reg(), OPC_OP, 2'b11};
    endcase
  endfunction

  function automatic string test_name(input int kind);
    case (kind)
      0: return "alu";
      1: return "load/store";
      2: return "branch/jump";
      3: return "invalid word";
      4: return "ecall";
      5: return "misaligned lw";
      6: return "misaligned lh";
      default: return "misaligned jalr";
    endcase
  endfunction

  task automatic build_program(input int kind);
    int p, k, trap_at;
    logic [31:0] r;
    logic [2:0] f3;
    logic [4:0] rd;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 4) ^ ((i * 4) * 32'h0001_0193) ^ 32'h5a5a_0000;
    end
    // x31 points at the data region, x1..x7 get random seeds
    mem[0] = {20'h00001, 5'd31, OPC_LUI, 2'b11};
    for (int i = 1; i < 8; i++) begin
      mem[i] = enc_i(12'(next_rand()), 5'd0, 3'd0, 5'(i), OPC_OP_IMM);
    end
    p = 8;
    while (p < PROG_LEN - 1) begin
      r = next_rand();
      k = 1 + (r[15:8] % 3);
      if (p + k > PROG_LEN - 1) k = PROG_LEN - 1 - p;
      if (kind == 1 && p + 3 <= PROG_LEN - 1) begin
        rd = rand_reg();
        f3 = 3'(r[7:4] % 3);
        mem[p] = enc_s(12'((r[23:16] >> f3) << f3), rand_reg(), f3);
        f3 = (r[3:0] % 5 == 3) ? 3'd4 : (r[3:0] % 5 == 4) ? 3'd5 : 3'(r[3:0] % 5);
        mem[p + 1] = enc_i(12'((r[31:24] >> f3[1:0]) << f3[1:0]), 5'd31, f3, rd, OPC_LOAD);
        mem[p + 2] = enc_s(12'(r[29:24] * 4), rd, 3'd2);
        p += 3;
      end else if (kind == 2) begin
        case (r[3:0] % 10)
          0, 1, 2, 3: mem[p] = random_alu();
          4, 5: mem[p] = enc_s(12'(r[21:16] * 4), rand_reg(), 3'd2);
          6, 7: begin
            f3 = (r[6:4] % 6 < 2) ? 3'(r[6:4] % 6) : 3'(r[6:4] % 6 + 2);
            mem[p] = enc_b(13'(k * 4), f3);
          end
          8: mem[p] = enc_j(21'(k * 4), rand_reg());
          default: mem[p] = enc_i(12'((p + k) * 4), 5'd0, 3'd0, rand_reg(), OPC_JALR);
        endcase
        p += 1;
      end else begin
        mem[p] = random_alu();
        if (p + 1 < PROG_LEN - 1) begin
          mem[p + 1] = enc_s(12'(r[21:16] * 4), mem[p][11:7], 3'd2);
        end
        p += 2;
      end
    end
    mem[PROG_LEN - 1] = 32'h0;
    trap_at = 8 + 2 * (next_rand() % 16);
    r = next_rand();
    case (kind)
      3: mem[trap_at] = r & ~32'h3;
      4: mem[trap_at] = 32'h0000_0073;
      5: mem[trap_at] = enc_i({4'b0, r[7:2], 2'(1 + r[9:8] % 3)}, 5'd31, 3'd2, 5'd1, OPC_LOAD);
      6: mem[trap_at] = enc_i({4'b0, r[7:1], 1'b1}, 5'd31, 3'd1, 5'd1, OPC_LOAD);
      7: mem[trap_at] = enc_i({4'b0, r[7:2], 2'b10}, 5'd0, 3'd0, 5'd1, OPC_JALR);
      default: ;
    endcase
    for (int i = 0; i < MEM_WORDS; i++) u_checker.mmem[i] = mem[i];
  endtask

  function automatic int total_errors();
    return u_checker.errors + i_dut.u_control.u_assertions.fail_count;
  endfunction

  initial begin
    forever #10 clk = ~clk;
  end

  // memory answers after 0 to 3 cycles, writes land with the strobes
  always @(negedge clk) begin
    if (reset) begin
      mem_ready = 1'b0;
    end else if (mem_ready) begin
      mem_ready = 1'b0;
      wait_cnt = next_rand() % 4;
    end else if (mem_valid) begin
      if (wait_cnt == 0) begin
        mem_rdata = mem[mem_addr[12:2]];
        for (int k = 0; k < 4; k++) begin
          if (mem_wstrb[k]) mem[mem_addr[12:2]][8*k +: 8] = mem_wdata[8*k +: 8];
        end
        mem_ready = 1'b1;
      end else begin
        wait_cnt--;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    wait_cnt = 0;
    failed_tests = 0;
    rng_state = 32'd79011;
    for (int t = 0; t < NUM_TESTS; t++) begin
      reset = 1'b1;
      build_program(t);
      repeat (8) @(negedge clk);
      prev_errs = total_errors();
      reset = 1'b0;
      while (trap !== 1'b1) @(negedge clk);
      repeat (6) @(negedge clk);
      test_errs = total_errors() - prev_errs;
      if (test_errs != 0) failed_tests++;
      $display("test %0d %s: %s, %0d errors", t, test_name(t),
               (test_errs == 0) ? "ok" : "failed", test_errs);
    end
    $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, total_errors());
    if (total_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_alu (
  input  rv_pkg::alu_op_e     alu_op,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  logic [2:0]          funct3,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = b[4:0];
  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_SLL: result = a << shamt;
      ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR: result = a ^ b;
      ALU_SRL: result = a >> shamt;
      ALU_SRA: result = $signed(a) >>> shamt;
      ALU_OR: result = a | b;
      ALU_AND: result = a & b;
      default: result = '0;
    endcase
  end

  // branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000: branch_taken = a == b;
      3'b001: branch_taken = a != b;
      3'b100: branch_taken = lt_signed;
      3'b101: branch_taken = !lt_signed;
      3'b110: branch_taken = lt_unsigned;
      3'b111: branch_taken = !lt_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

//--- verilog/rv_control.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_control (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      is_lui,
  input  logic                      is_auipc,
  input  logic                      is_jal,
  input  logic                      is_jalr,
  input  logic                      is_branch,
  input  logic                      is_load,
  input  logic                      is_store,
  input  logic                      is_alu_imm,
  input  logic                      is_alu_reg,
  input  logic [`RV_XLEN-1:0]       immediate,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic                      valid,
  output logic [`RV_XLEN-1:0]       instr,
  input  logic [`RV_XLEN-1:0]       rs1_data,
  input  logic [`RV_XLEN-1:0]       rs2_data,
  input  logic [`RV_XLEN-1:0]       alu_result,
  input  logic                      branch_taken,
  input  logic [`RV_XLEN-1:0]       word_addr,
  input  logic [`RV_STRB_W-1:0]     wstrb,
  input  logic [`RV_XLEN-1:0]       wdata,
  input  logic                      misaligned,
  input  logic [`RV_XLEN-1:0]       load_value,
  output logic [`RV_XLEN-1:0]       alu_b,
  output logic                      reg_we,
  output logic [`RV_REG_ADDR_W-1:0] reg_rd,
  output logic [`RV_XLEN-1:0]       reg_wdata,
  output logic                      mem_valid,
  output logic                      mem_instr,
  output logic [`RV_XLEN-1:0]       mem_addr,
  output logic [`RV_XLEN-1:0]       mem_wdata,
  output logic [`RV_STRB_W-1:0]     mem_wstrb,
  input  logic                      mem_ready,
  input  logic [`RV_XLEN-1:0]       mem_rdata,
  output logic                      trap
);
  import rv_pkg::*;

  cpu_state_e state;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] target;
  logic [`RV_XLEN-1:0] wb_value;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] jump_target;
  logic [`RV_XLEN-1:0] branch_target;

  assign pc_plus4 = pc + 32'd4;
  // jalr clears bit 0 as the spec says, bit 1 is left for the pc check
  assign jump_target = is_jalr ? ((rs1_data + immediate) & ~32'h1) : pc + immediate;
  assign branch_target = branch_taken ? pc + immediate : pc_plus4;

  assign alu_b = is_alu_imm ? immediate : rs2_data;

  assign reg_we = state == ST_REG_WRITE;
  assign reg_rd = rd;
  assign reg_wdata = wb_value;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
      next_pc <= `RV_RESET_PC;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
      trap <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= '0;
          mem_addr <= next_pc;
          state <= ST_READY;
        end
        ST_READY: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            pc <= mem_addr;
            instr <= mem_rdata;
            state <= ST_DECODE;
          end
        end
        // decoder and register reads settle here
        ST_DECODE: state <= ST_EXECUTE;
        ST_EXECUTE: begin
          if (!valid) begin
            state <= ST_TRAP;
          end else if (is_lui || is_auipc) begin
            wb_value <= is_lui ? immediate : pc + immediate;
            next_pc <= pc_plus4;
            state <= ST_REG_WRITE;
          end else if (is_jal || is_jalr) begin
            target <= jump_target;
            wb_value <= pc_plus4;
            state <= ST_CHECK_PC;
          end else if (is_branch) begin
            target <= branch_target;
            state <= ST_CHECK_PC;
          end else if (is_load || is_store) begin
            if (misaligned) begin
              state <= ST_TRAP;
            end else begin
              mem_valid <= 1'b1;
              mem_instr <= 1'b0;
              mem_addr <= word_addr;
              mem_wstrb <= is_store ? wstrb : '0;
              mem_wdata <= wdata;
              state <= is_store ? ST_FINISH_STORE : ST_FINISH_LOAD;
            end
          end else if (is_alu_imm || is_alu_reg) begin
            wb_value <= alu_result;
            next_pc <= pc_plus4;
            state <= ST_REG_WRITE;
          end else begin
            state <= ST_TRAP;
          end
        end
        ST_FINISH_LOAD: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            wb_value <= load_value;
            next_pc <= pc_plus4;
            state <= ST_REG_WRITE;
          end
        end
        ST_FINISH_STORE: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            mem_wstrb <= '0;
            next_pc <= pc_plus4;
            state <= ST_FETCH;
          end
        end
        ST_CHECK_PC: begin
          if (target[1:0] != 2'b00) begin
            state <= ST_TRAP;
          end else begin
            next_pc <= target;
            state <= is_branch ? ST_FETCH : ST_REG_WRITE;
          end
        end
        ST_REG_WRITE: state <= ST_FETCH;
        ST_TRAP: trap <= 1'b1;
        default: state <= ST_TRAP;
      endcase
    end
  end

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  mem_valid,
  output logic                  mem_instr,
  input  logic                  mem_ready,
  output logic [`RV_XLEN-1:0]   mem_addr,
  output logic [`RV_XLEN-1:0]   mem_wdata,
  output logic [`RV_STRB_W-1:0] mem_wstrb,
  input  logic [`RV_XLEN-1:0]   mem_rdata,
  output logic                  trap
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] instr;
  logic is_lui, is_auipc, is_jal, is_jalr, is_branch;
  logic is_load, is_store, is_alu_imm, is_alu_reg;
  alu_op_e alu_op;
  logic [2:0] funct3;
  logic [`RV_XLEN-1:0] immediate;
  logic [`RV_REG_ADDR_W-1:0] dec_rd, dec_rs1, dec_rs2;
  logic valid;

  logic [`RV_XLEN-1:0] rs1_data, rs2_data;
  logic reg_we;
  logic [`RV_REG_ADDR_W-1:0] reg_rd;
  logic [`RV_XLEN-1:0] reg_wdata;

  logic [`RV_XLEN-1:0] alu_b, alu_result;
  logic branch_taken;

  logic [`RV_XLEN-1:0] word_addr, lsu_wdata, load_value;
  logic [`RV_STRB_W-1:0] lsu_wstrb;
  logic misaligned;

  rv_decoder u_decoder (
    .instr(instr), .is_lui(is_lui), .is_auipc(is_auipc), .is_jal(is_jal),
    .is_jalr(is_jalr), .is_branch(is_branch), .is_load(is_load), .is_store(is_store),
    .is_alu_imm(is_alu_imm), .is_alu_reg(is_alu_reg), .alu_op(alu_op), .funct3(funct3),
    .immediate(immediate), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2), .valid(valid)
  );

  rv_regfile u_regfile (
    .clk(clk), .rs1(dec_rs1), .rs2(dec_rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(reg_we), .rd(reg_rd), .rd_data(reg_wdata)
  );

  rv_alu u_alu (
    .alu_op(alu_op), .a(rs1_data), .b(alu_b), .funct3(funct3),
    .result(alu_result), .branch_taken(branch_taken)
  );

  // rs1 is the address base, rs2 the store source
  rv_lsu u_lsu (
    .base(rs1_data), .immediate(immediate), .funct3(funct3), .store_data(rs2_data),
    .rdata(mem_rdata), .word_addr(word_addr), .wstrb(lsu_wstrb), .wdata(lsu_wdata),
    .misaligned(misaligned), .load_value(load_value)
  );

  rv_control u_control (
    .clk(clk), .reset(reset), .is_lui(is_lui), .is_auipc(is_auipc), .is_jal(is_jal),
    .is_jalr(is_jalr), .is_branch(is_branch), .is_load(is_load), .is_store(is_store),
    .is_alu_imm(is_alu_imm), .is_alu_reg(is_alu_reg), .immediate(immediate), .rd(dec_rd),
    .valid(valid), .instr(instr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .alu_result(alu_result), .branch_taken(branch_taken), .word_addr(word_addr),
    .wstrb(lsu_wstrb), .wdata(lsu_wdata), .misaligned(misaligned), .load_value(load_value),
    .alu_b(alu_b), .reg_we(reg_we), .reg_rd(reg_rd), .reg_wdata(reg_wdata),
    .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_ready(mem_ready),
    .mem_rdata(mem_rdata), .trap(trap)
  );

endmodule

//--- verilog/rv_decoder.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_decoder (
  input  logic [`RV_XLEN-1:0]       instr,
  output logic                      is_lui,
  output logic                      is_auipc,
  output logic                      is_jal,
  output logic                      is_jalr,
  output logic                      is_branch,
  output logic                      is_load,
  output logic                      is_store,
  output logic                      is_alu_imm,
  output logic                      is_alu_reg,
  output rv_pkg::alu_op_e           alu_op,
  output logic [2:0]                funct3,
  output logic [`RV_XLEN-1:0]       immediate,
  output logic [`RV_REG_ADDR_W-1:0] rd,
  output logic [`RV_REG_ADDR_W-1:0] rs1,
  output logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic                      valid
);
  import rv_pkg::*;

  opcode_e opcode;
  logic [6:0] funct7;
  logic f7_zero;
  logic f7_alt;
  logic [`RV_XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;

  assign opcode = opcode_e'(instr[6:2]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign f7_zero = funct7 == 7'b0000000;
  assign f7_alt = funct7 == 7'b0100000;

  assign rd = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'b0};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    is_lui = 1'b0;
    is_auipc = 1'b0;
    is_jal = 1'b0;
    is_jalr = 1'b0;
    is_branch = 1'b0;
    is_load = 1'b0;
    is_store = 1'b0;
    is_alu_imm = 1'b0;
    is_alu_reg = 1'b0;
    valid = 1'b0;
    immediate = '0;
    // quadrants 0..2 are compressed encodings, left invalid
    if (instr[1:0] == 2'b11) begin
      case (opcode)
        OPC_LUI: begin
          is_lui = 1'b1;
          immediate = u_imm;
          valid = 1'b1;
        end
        OPC_AUIPC: begin
          is_auipc = 1'b1;
          immediate = u_imm;
          valid = 1'b1;
        end
        OPC_JAL: begin
          is_jal = 1'b1;
          immediate = j_imm;
          valid = 1'b1;
        end
        OPC_JALR: begin
          is_jalr = 1'b1;
          immediate = i_imm;
          valid = funct3 == 3'b000;
        end
        OPC_BRANCH: begin
          is_branch = 1'b1;
          immediate = b_imm;
          valid = funct3[2:1] != 2'b01;
        end
        OPC_LOAD: begin
          is_load = 1'b1;
          immediate = i_imm;
          valid = funct3 != 3'b011 && funct3[2:1] != 2'b11;
        end
        OPC_STORE: begin
          is_store = 1'b1;
          immediate = s_imm;
          valid = funct3[2] == 1'b0 && funct3[1:0] != 2'b11;
        end
        OPC_OP_IMM: begin
          is_alu_imm = 1'b1;
          immediate = i_imm;
          case (funct3)
            3'b001: valid = f7_zero;
            3'b101: valid = f7_zero || f7_alt;
            default: valid = 1'b1;
          endcase
        end
        OPC_OP: begin
          is_alu_reg = 1'b1;
          valid = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        end
        // ecall, ebreak and csr accesses all trap
        OPC_SYSTEM: valid = 1'b0;
        default: valid = 1'b0;
      endcase
    end
  end

  // immediate forms reuse the same ops, shift amount sits in imm[4:0]
  always_comb begin
    alu_op = ALU_ADD;
    if (is_alu_imm || is_alu_reg) begin
      case (funct3)
        3'b000: alu_op = (is_alu_reg && funct7[5]) ? ALU_SUB : ALU_ADD;
        3'b001: alu_op = ALU_SLL;
        3'b010: alu_op = ALU_SLT;
        3'b011: alu_op = ALU_SLTU;
        3'b100: alu_op = ALU_XOR;
        3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
        3'b110: alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

endmodule

//--- verilog/rv_lsu.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_lsu (
  input  logic [`RV_XLEN-1:0]   base,
  input  logic [`RV_XLEN-1:0]   immediate,
  input  logic [2:0]            funct3,
  input  logic [`RV_XLEN-1:0]   store_data,
  input  logic [`RV_XLEN-1:0]   rdata,
  output logic [`RV_XLEN-1:0]   word_addr,
  output logic [`RV_STRB_W-1:0] wstrb,
  output logic [`RV_XLEN-1:0]   wdata,
  output logic                  misaligned,
  output logic [`RV_XLEN-1:0]   load_value
);

  logic [`RV_XLEN-1:0] addr;
  logic [1:0] offset;
  logic [`RV_XLEN-1:0] lane_data;
  logic [7:0] load_byte;
  logic [15:0] load_half;

  assign addr = base + immediate;
  assign offset = addr[1:0];
  assign word_addr = {addr[`RV_XLEN-1:2], 2'b00};

  // funct3[1:0] is the access size for both loads and stores
  assign misaligned = (funct3[1:0] == 2'b01 && offset[0]) ||
                      (funct3[1:0] == 2'b10 && offset != 2'b00);

  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        wstrb = {{(`RV_STRB_W-1){1'b0}}, 1'b1} << offset;
        wdata = {4{store_data[7:0]}};
      end
      2'b01: begin
        wstrb = offset[1] ? 4'b1100 : 4'b0011;
        wdata = {2{store_data[15:0]}};
      end
      default: begin
        wstrb = '1;
        wdata = store_data;
      end
    endcase
  end

  // move the addressed lane down to bit 0
  assign lane_data = rdata >> {offset, 3'b000};
  assign load_byte = lane_data[7:0];
  assign load_half = lane_data[15:0];

  always_comb begin
    case (funct3)
      3'b000: load_value = {{24{load_byte[7]}}, load_byte};
      3'b100: load_value = {24'b0, load_byte};
      3'b001: load_value = {{16{load_half[15]}}, load_half};
      3'b101: load_value = {16'b0, load_half};
      default: load_value = rdata;
    endcase
  end

endmodule

//--- verilog/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and address width
`define RV_XLEN 32

// integer register file
`define RV_REG_COUNT 32
`define RV_REG_ADDR_W 5

// first instruction fetch after reset
`define RV_RESET_PC 32'h0000_0000

// byte lanes per bus word
`define RV_STRB_W 4

`endif

//--- verilog/rv_pkg.sv
package rv_pkg;

  // major opcode, instr[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_OP_IMM = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_OP     = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011,
    OPC_SYSTEM = 5'b11100
  } opcode_e;

  typedef enum logic [3:0] {
    ST_FETCH,
    ST_READY,
    ST_DECODE,
    ST_EXECUTE,
    ST_FINISH_LOAD,
    ST_FINISH_STORE,
    ST_CHECK_PC,
    ST_REG_WRITE,
    ST_TRAP
  } cpu_state_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

endpackage

//--- verilog/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data,
  input  logic                      we,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic [`RV_XLEN-1:0]       rd_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- vlog.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_control.sv
verilog/rv_core.sv
tb/rv_core_assertions.sv
tb/rv_checker.sv
tb/tb_rv_core.sv
